//--- all.f
hw/rmt_pkg.sv
hw/pkt_filter.sv
hw/phv_parser.sv
hw/action_stage.sv
hw/sync_fifo.sv
hw/deparser.sv
hw/rmt_pipeline.sv
verif/rmt_pipeline_tb.sv

//--- hw/action_stage.sv
module action_stage #(
	parameter int STAGE_ID = 0
) (
	input  logic                      clk,
	input  logic                      aresetn,

	input  logic [rmt_pkg::PHV_W-1:0] phv_in,
	input  logic                      phv_in_valid,
	output logic                      stage_ready_out,

	output logic [rmt_pkg::PHV_W-1:0] phv_out,
	output logic                      phv_out_valid,
	input  logic                      stage_ready_in
);

	import rmt_pkg::*;

	logic [PHV_W-1:0]  phv_q;
	logic              valid_q;
	logic [CONT_W-1:0] dst;
	logic [CONT_W-1:0] src;
	logic [CONT_W-1:0] res;

	assign dst = phv_in[STAGE_ID*CONT_W +: CONT_W];
	assign src = phv_in[((STAGE_ID + 1) % NUM_CONT)*CONT_W +: CONT_W];

	always_comb begin
		case (STAGE_OP[STAGE_ID])
			op_add:  res = dst + src;
			op_xor:  res = dst ^ src;
			op_sub:  res = dst - src;
			op_copy: res = src;
			default: res = dst;
		endcase
	end

	// one slot, refilled while it drains
	assign stage_ready_out = !valid_q || stage_ready_in;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			valid_q <= 1'b0;
		end else if (stage_ready_out) begin
			valid_q <= phv_in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid && stage_ready_out) begin
			phv_q <= phv_in;
			phv_q[STAGE_ID*CONT_W +: CONT_W] <= res;
		end
	end

	assign phv_out = phv_q;
	assign phv_out_valid = valid_q;

	// stalled output holds its value
	a_hold: assert property (
		@(posedge clk) disable iff (!aresetn)
		(phv_out_valid && !stage_ready_in) |=> (phv_out_valid && $stable(phv_out))
	);

endmodule

//--- hw/deparser.sv
module deparser (
	input  logic                       clk,
	input  logic                       aresetn,

	input  logic [rmt_pkg::DATA_W:0]   pkt_dout,
	input  logic                       pkt_empty,
	output logic                       pkt_rd_en,

	input  logic [rmt_pkg::PHV_W-1:0]  phv_dout,
	input  logic                       phv_empty,
	output logic                       phv_rd_en,

	output logic [rmt_pkg::DATA_W-1:0] m_tdata,
	output logic                       m_tvalid,
	output logic                       m_tlast,
	input  logic                       m_tready
);

	import rmt_pkg::*;

	typedef enum logic {
		dep_header,
		dep_payload
	} dep_state_t;

	dep_state_t state;
	logic       xfer;

	// header needs its processed phv as well as the stored beat
	always_comb begin
		if (state == dep_header) begin
			m_tvalid = !pkt_empty && !phv_empty;
			m_tdata = phv_dout;
		end else begin
			m_tvalid = !pkt_empty;
			m_tdata = pkt_dout[DATA_W-1:0];
		end
	end

	assign m_tlast = pkt_dout[DATA_W];
	assign xfer = m_tvalid && m_tready;

	assign pkt_rd_en = xfer;
	assign phv_rd_en = xfer && (state == dep_header);

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= dep_header;
		end else if (xfer) begin
			// any last beat closes the packet
			if (m_tlast) begin
				state <= dep_header;
			end else begin
				state <= dep_payload;
			end
		end
	end

	// a waiting phv always has its stored header beat
	a_phv_has_pkt: assert property (
		@(posedge clk) disable iff (!aresetn)
		(state == dep_header && !phv_empty) |-> !pkt_empty
	);

endmodule

//--- hw/phv_parser.sv
module phv_parser (
	input  logic                         clk,
	input  logic                         aresetn,

	input  logic [rmt_pkg::DATA_W-1:0]   flt_tdata,
	input  logic                         flt_tvalid,
	input  logic                         flt_tlast,
	output logic                         flt_tready,

	output logic [rmt_pkg::PHV_W-1:0]    phv,
	output logic                         phv_valid,
	input  logic                         phv_ready,

	output logic                         pkt_wr_en,
	output logic [rmt_pkg::DATA_W:0]     pkt_din,
	input  logic                         pkt_nearly_full
);

	logic sop;

	// header beat needs both the stage chain and the packet fifo
	assign flt_tready = !pkt_nearly_full && (!sop || phv_ready);

	assign phv = flt_tdata;
	assign phv_valid = flt_tvalid && sop && !pkt_nearly_full;

	// every beat, header included, is stored with its last flag
	assign pkt_wr_en = flt_tvalid && flt_tready;
	assign pkt_din = {flt_tlast, flt_tdata};

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			sop <= 1'b1;
		end else if (flt_tvalid && flt_tready) begin
			sop <= flt_tlast;
		end
	end

	// header and its stored copy must leave together
	a_hdr_with_pkt: assert property (
		@(posedge clk) disable iff (!aresetn)
		(phv_valid && phv_ready) |-> pkt_wr_en
	);

endmodule

//--- hw/pkt_filter.sv
module pkt_filter (
	input  logic                       clk,
	input  logic                       aresetn,

	input  logic [rmt_pkg::DATA_W-1:0] s_tdata,
	input  logic                       s_tvalid,
	input  logic                       s_tlast,
	output logic                       s_tready,

	output logic [rmt_pkg::DATA_W-1:0] flt_tdata,
	output logic                       flt_tvalid,
	output logic                       flt_tlast,
	input  logic                       flt_tready
);

	import rmt_pkg::*;

	logic sop;
	logic drop_q;
	logic hdr_ok;
	logic drop;

	// protocol number sits in the top container
	assign hdr_ok = (s_tdata[3*CONT_W +: CONT_W] == PROTO_ACCEPT);

	// header decides now, later beats follow the stored decision
	assign drop = sop ? !hdr_ok : drop_q;

	assign flt_tdata = s_tdata;
	assign flt_tlast = s_tlast;
	assign flt_tvalid = s_tvalid && !drop;

	// dropped beats are swallowed at full rate
	assign s_tready = drop || flt_tready;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			sop <= 1'b1;
			drop_q <= 1'b0;
		end else if (s_tvalid && s_tready) begin
			sop <= s_tlast;
			if (sop) begin
				drop_q <= !hdr_ok;
			end
		end
	end

endmodule

//--- hw/rmt_pipeline.sv
module rmt_pipeline (
	input  logic                       clk,
	input  logic                       aresetn,

	input  logic [rmt_pkg::DATA_W-1:0] s_tdata,
	input  logic                       s_tvalid,
	output logic                       s_tready,
	input  logic                       s_tlast,

	output logic [rmt_pkg::DATA_W-1:0] m_tdata,
	output logic                       m_tvalid,
	input  logic                       m_tready,
	output logic                       m_tlast
);

	import rmt_pkg::*;

	logic [DATA_W-1:0] flt_tdata;
	logic              flt_tvalid;
	logic              flt_tlast;
	logic              flt_tready;

	// index 0 is the parser output, k+1 is stage k output
	logic [NUM_STAGES:0][PHV_W-1:0] stg_phv;
	logic [NUM_STAGES:0]            stg_valid;
	logic [NUM_STAGES:0]            stg_ready;

	logic              pkt_wr_en;
	logic [DATA_W:0]   pkt_din;
	logic              pkt_nearly_full;
	logic              pkt_rd_en;
	logic [DATA_W:0]   pkt_dout;
	logic              pkt_empty;

	logic              phv_wr_en;
	logic              phv_nearly_full;
	logic              phv_rd_en;
	logic [PHV_W-1:0]  phv_dout;
	logic              phv_empty;

	pkt_filter pkt_filter_i (
		.clk, .aresetn,
		.s_tdata, .s_tvalid, .s_tlast, .s_tready,
		.flt_tdata, .flt_tvalid, .flt_tlast, .flt_tready
	);

	phv_parser phv_parser_i (
		.clk, .aresetn,
		.flt_tdata, .flt_tvalid, .flt_tlast, .flt_tready,
		.phv(stg_phv[0]), .phv_valid(stg_valid[0]), .phv_ready(stg_ready[0]),
		.pkt_wr_en, .pkt_din, .pkt_nearly_full
	);

	for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
		action_stage #(.STAGE_ID(k)) stage_i (
			.clk, .aresetn,
			.phv_in(stg_phv[k]), .phv_in_valid(stg_valid[k]), .stage_ready_out(stg_ready[k]),
			.phv_out(stg_phv[k+1]), .phv_out_valid(stg_valid[k+1]),
			.stage_ready_in(stg_ready[k+1])
		);
	end

	assign stg_ready[NUM_STAGES] = !phv_nearly_full;
	assign phv_wr_en = stg_valid[NUM_STAGES] && stg_ready[NUM_STAGES];

	sync_fifo #(.WIDTH(DATA_W+1)) pkt_fifo (
		.clk, .aresetn,
		.wr_en(pkt_wr_en), .din(pkt_din), .rd_en(pkt_rd_en),
		.dout(pkt_dout), .empty(pkt_empty), .nearly_full(pkt_nearly_full)
	);

	sync_fifo #(.WIDTH(PHV_W)) phv_fifo (
		.clk, .aresetn,
		.wr_en(phv_wr_en), .din(stg_phv[NUM_STAGES]), .rd_en(phv_rd_en),
		.dout(phv_dout), .empty(phv_empty), .nearly_full(phv_nearly_full)
	);

	deparser deparser_i (
		.clk, .aresetn,
		.pkt_dout, .pkt_empty, .pkt_rd_en,
		.phv_dout, .phv_empty, .phv_rd_en,
		.m_tdata, .m_tvalid, .m_tlast, .m_tready
	);

endmodule

//--- hw/rmt_pkg.sv
package rmt_pkg;

	// stream and header vector widths
	localparam int DATA_W = 32;
	localparam int CONT_W = 8;
	localparam int NUM_CONT = 4;
	localparam int PHV_W = CONT_W * NUM_CONT;

	// only this protocol number in container 3 gets through
	localparam logic [CONT_W-1:0] PROTO_ACCEPT = 8'h11;

	localparam int NUM_STAGES = 4;

	// fifo geometry
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;
	localparam int NEARLY_FULL_GAP = 2;

	// dst is container k, src is container k+1
	typedef enum logic [1:0] {
		op_add,
		op_xor,
		op_sub,
		op_copy
	} stage_op_t;

	// fixed per-stage action
	localparam stage_op_t STAGE_OP [NUM_STAGES] = '{
		op_add,
		op_xor,
		op_sub,
		op_copy
	};

endpackage

//--- hw/sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             aresetn,

	input  logic             wr_en,
	input  logic [WIDTH-1:0] din,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             nearly_full
);

	import rmt_pkg::*;

	logic [WIDTH-1:0]   mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;

	assign empty = (count == '0);
	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign nearly_full = (count >= (FIFO_AW+1)'(FIFO_DEPTH - NEARLY_FULL_GAP));

	// show-ahead head
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!aresetn) wr_en |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!aresetn) rd_en |-> !empty);

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module rmt_pipeline_tb -f all.f -o sim_rmt_pipeline
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_rmt_pipeline)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

//--- verif/rmt_pipeline_tb.sv
module rmt_pipeline_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rmt_pkg::*;

	localparam int NUM_PKTS = 60;
	localparam logic [31:0] SEED = 32'h03a47f7e;
	// per-packet budget plus drain margin
	localparam int CYCLE_LIMIT = 40 * NUM_PKTS + 200;

	logic              clk;
	logic              aresetn;
	logic [DATA_W-1:0] s_tdata;
	logic              s_tvalid;
	logic              s_tready;
	logic              s_tlast;
	logic [DATA_W-1:0] m_tdata;
	logic              m_tvalid;
	logic              m_tready;
	logic              m_tlast;

	// expected output beats with the last flag on top
	logic [DATA_W:0] exp_q [$];

	logic [31:0] stim_state;
	logic [31:0] rdy_state;
	int          stall_cnt;
	int          cycles = 0;

	rmt_pipeline rmt_pipeline_i (
		.clk, .aresetn,
		.s_tdata, .s_tvalid, .s_tready, .s_tlast,
		.m_tdata, .m_tvalid, .m_tready, .m_tlast
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// stage k writes byte k from byte k+1 in stage order
	function automatic logic [31:0] expected_header(input logic [31:0] hdr);
		logic [7:0] c [4];
		for (int i = 0; i < 4; i++) begin
			c[i] = hdr[8*i +: 8];
		end
		c[0] = c[0] + c[1];
		c[1] = c[1] ^ c[2];
		c[2] = c[2] - c[3];
		c[3] = c[0];
		return {c[3], c[2], c[1], c[0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
		if (want !== got) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, want, got);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s at %0t", why, $time);
		$display("Finished with errors");
		$fatal(1, "run aborted");
	endtask

	task automatic send_beat(input logic [31:0] data, input logic last);
		s_tdata <= data;
		s_tlast <= last;
		s_tvalid <= 1'b1;
		@(posedge clk);
		while (!s_tready) begin
			@(posedge clk);
		end
	endtask

	task automatic send_packet();
		logic [31:0] r;
		logic [31:0] beat;
		logic [7:0]  proto;
		logic        keep;
		logic        last_beat;
		int          len;
		stim_state = lcg_next(stim_state);
		r = stim_state;
		len = int'(r[23:16]) % 6 + 1;
		keep = (r[31:28] < 4'd11);
		// rejected packets get any byte but the accepted one
		proto = keep ? PROTO_ACCEPT : ((r[7:0] == PROTO_ACCEPT) ? 8'h12 : r[7:0]);
		for (int b = 0; b < len; b++) begin
			stim_state = lcg_next(stim_state);
			beat = stim_state;
			last_beat = (b == len - 1);
			if (b == 0) begin
				beat[31:24] = proto;
			end
			if (keep) begin
				exp_q.push_back({last_beat, (b == 0) ? expected_header(beat) : beat});
			end
			send_beat(beat, last_beat);
		end
		stim_state = lcg_next(stim_state);
		// mostly back to back with an occasional idle gap
		if (stim_state[31:29] == 3'd0) begin
			s_tvalid <= 1'b0;
			repeat (int'(stim_state[27:24])) @(posedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		aresetn = 1'b0;
		s_tdata = '0;
		s_tvalid = 1'b0;
		s_tlast = 1'b0;
		stim_state = SEED;
		repeat (10) @(posedge clk);
		aresetn <= 1'b1;
		repeat (5) @(posedge clk);
		for (int p = 0; p < NUM_PKTS; p++) begin
			send_packet();
		end
		s_tvalid <= 1'b0;
		s_tlast <= 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		// catch any extra beat after the last expected one
		repeat (30) @(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

	// sink readiness with short gaps and rare long stalls
	initial begin
		m_tready = 1'b0;
		rdy_state = lcg_next(SEED ^ 32'h0000_ffff);
		stall_cnt = 0;
		forever begin
			@(posedge clk);
			rdy_state = lcg_next(rdy_state);
			if (stall_cnt > 0) begin
				stall_cnt--;
				m_tready <= 1'b0;
			end else if (rdy_state[31:27] == 5'd0) begin
				stall_cnt = 8 + int'(rdy_state[20:16]);
				m_tready <= 1'b0;
			end else begin
				m_tready <= (rdy_state[26:24] != 3'd0);
			end
		end
	end

	// nothing may be offered while no accepted beat is pending
	always @(posedge clk) begin : compare
		logic [DATA_W:0] want;
		if (!aresetn || exp_q.size() == 0) begin
			check_value("m_tvalid", 32'd0, {31'd0, m_tvalid});
		end else if (m_tvalid && m_tready) begin
			want = exp_q.pop_front();
			check_value("m_tdata", want[DATA_W-1:0], m_tdata);
			check_value("m_tlast", {31'd0, want[DATA_W]}, {31'd0, m_tlast});
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			fail_run("timeout, output stalled before all expected beats arrived");
		end
	end

endmodule
